/* common/game_defs.svh */
// game-wide constants: card count, score limit, timer reload, tick length, segment width
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// one switch per card
`define CARD_COUNT 18

// last digit before a score wraps to 0
`define SCORE_MAX 9

// countdown start and wrap value
`define TIMER_RELOAD 8'hFF

// 50 MHz board clock gives one tick per second
`define TICK_CYCLES_DEFAULT 50000000

// seven-segment digit, one bit per segment
`define SEG_WIDTH 7

`endif

/* common/game_pkg.sv */
// game types: card set, player, score digit, control FSM state
`include "game_defs.svh"

package game_pkg;

	// one bit per switch, a set bit marks a card
	typedef logic [`CARD_COUNT-1:0] card_set_t;

	// 0 is player one
	typedef logic player_t;

	localparam player_t player_one = 1'b0;
	localparam player_t player_two = 1'b1;

	// one decimal digit per player
	typedef logic [3:0] score_t;

	// each pair of states waits for a press, then for the release
	typedef enum logic [2:0]
	{
		select_one      = 3'd0,
		select_one_wait = 3'd1,
		select_two      = 3'd2,
		select_two_wait = 3'd3,
		check           = 3'd4,
		check_wait      = 3'd5
	} fsm_state_t;

endpackage

/* common/display_pkg.sv */
// display types: segment pattern, glyph code, lead code
`include "game_defs.svh"

package display_pkg;

	// active low, bit 0 is segment a
	typedef logic [`SEG_WIDTH-1:0] seg_t;

	// 0 to 9 are digits, the rest depend on the letter set
	typedef logic [3:0] glyph_t;

	// player letter set
	localparam glyph_t glyph_p     = 4'hA;
	localparam glyph_t glyph_blank = 4'hB;

	// who is ahead
	typedef logic [3:0] lead_t;

	localparam lead_t lead_tie = 4'd0;
	localparam lead_t lead_one = 4'd1;
	localparam lead_t lead_two = 4'd2;

	localparam seg_t seg_off = 7'b1111111; // all segments dark

endpackage

/* game/turn_fsm.sv */
// control FSM for selecting two cards and checking them, driven by the go key
module turn_fsm
(
	input  logic clock,
	input  logic reset_n,
	input  logic go,
	output logic select_one,
	output logic select_two,
	output logic check_pulse
);

	game_pkg::fsm_state_t state;
	game_pkg::fsm_state_t next_state;

	always_comb
	begin
		case (state)
			game_pkg::select_one:
				next_state = go ? game_pkg::select_one_wait : game_pkg::select_one;
			game_pkg::select_one_wait:
				next_state = go ? game_pkg::select_one_wait : game_pkg::select_two;
			game_pkg::select_two:
				next_state = go ? game_pkg::select_two_wait : game_pkg::select_two;
			game_pkg::select_two_wait:
				next_state = go ? game_pkg::select_two_wait : game_pkg::check;
			game_pkg::check:
				next_state = go ? game_pkg::check_wait : game_pkg::check;
			game_pkg::check_wait:
				next_state = go ? game_pkg::check_wait : game_pkg::select_one;
			default:
				next_state = game_pkg::select_one;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state       <= game_pkg::select_one;
			check_pulse <= 1'b0;
		end
		else
		begin
			state       <= next_state;
			// first cycle of check only
			check_pulse <= (state == game_pkg::select_two_wait) && !go;
		end
	end

	// card loads stay open through the wait states
	assign select_one = (state == game_pkg::select_one) || (state == game_pkg::select_one_wait);
	assign select_two = (state == game_pkg::select_two) || (state == game_pkg::select_two_wait);

	// the check pulse must never overlap a card load
	a_exclusive_controls : assert property (
		@(posedge clock) disable iff (!reset_n)
		$onehot0({select_one, select_two, check_pulse})
	);

endmodule

/* game/match_datapath.sv */
// card selection registers, pair table check, turn and match flag
module match_datapath
(
	input  logic                clock,
	input  logic                reset_n,
	input  game_pkg::card_set_t switches,
	input  logic                select_one,
	input  logic                select_two,
	input  logic                check_pulse,
	output logic                scored,
	output game_pkg::player_t   turn,
	output logic                match_led
);

	localparam int pair_count = 9;

	// card pair_hi[i] goes with card pair_lo[i]
	localparam int pair_hi [pair_count] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};
	localparam int pair_lo [pair_count] = '{10, 0, 4, 3, 2, 11, 7, 5, 1};

	game_pkg::card_set_t card_one;
	game_pkg::card_set_t card_two;
	logic                is_match;

	// follow the switches while a selection is open
	always_ff @(posedge clock)
	begin
		if (select_one)
			card_one <= switches;
		if (select_two)
			card_two <= switches;
	end

	// either order counts
	always_comb
	begin
		is_match = 1'b0;
		for (int i = 0; i < pair_count; i++)
		begin
			if ((card_one[pair_hi[i]] && card_two[pair_lo[i]]) ||
				(card_two[pair_hi[i]] && card_one[pair_lo[i]]))
				is_match = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			scored    <= 1'b0;
			turn      <= game_pkg::player_one;
			match_led <= 1'b0;
		end
		else
		begin
			scored <= check_pulse && is_match; // one cycle per check
			if (check_pulse)
			begin
				match_led <= is_match;
				if (!is_match)
					turn <= ~turn; // miss passes the turn
			end
		end
	end

	// a check happens at most once per three key presses
	a_scored_single : assert property (
		@(posedge clock) disable iff (!reset_n)
		scored |=> !scored
	);

endmodule

/* design/score_keeper.sv */
// wrapping score digits for both players and the lead comparison
`include "game_defs.svh"

module score_keeper
(
	input  logic                  clock,
	input  logic                  reset_n,
	input  logic                  scored,
	input  game_pkg::player_t     turn,
	output game_pkg::score_t      score_one,
	output game_pkg::score_t      score_two,
	output display_pkg::lead_t    lead
);

	function automatic game_pkg::score_t next_digit(input game_pkg::score_t digit);
		if (digit == game_pkg::score_t'(`SCORE_MAX))
			return '0;
		return digit + 4'd1;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			score_one <= '0;
			score_two <= '0;
		end
		else if (scored)
		begin
			if (turn == game_pkg::player_one)
				score_one <= next_digit(score_one);
			else
				score_two <= next_digit(score_two);
		end
	end

	always_comb
	begin
		if (score_one > score_two)
			lead = display_pkg::lead_one;
		else if (score_two > score_one)
			lead = display_pkg::lead_two;
		else
			lead = display_pkg::lead_tie;
	end

	// the wrap keeps both digits decimal
	a_score_range : assert property (
		@(posedge clock) disable iff (!reset_n)
		(score_one <= `SCORE_MAX) && (score_two <= `SCORE_MAX)
	);

endmodule

/* design/countdown_timer.sv */
// rate divider, free-running 8-bit countdown and flash phase
`include "game_defs.svh"

module countdown_timer
#(
	parameter int tick_cycles = `TICK_CYCLES_DEFAULT
)
(
	input  logic       clock,
	input  logic       reset_n,
	output logic [7:0] count,
	output logic       flash_phase
);

	localparam int div_width = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

	logic [div_width-1:0] divider;
	logic                 tick;

	// last divider value of each period
	assign tick = (divider == div_width'(tick_cycles - 1));

	always_ff @(posedge clock)
	begin
		if (!reset_n)
			divider <= '0;
		else if (tick)
			divider <= '0;
		else
			divider <= divider + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			count       <= `TIMER_RELOAD;
			flash_phase <= 1'b0;
		end
		else if (tick)
		begin
			// 00 goes back to the top
			if (count == 8'h00)
				count <= `TIMER_RELOAD;
			else
				count <= count - 8'd1;
			flash_phase <= ~flash_phase;
		end
	end

	a_divider_range : assert property (
		@(posedge clock) disable iff (!reset_n)
		divider < tick_cycles
	);

endmodule

/* design/seg_decoder.sv */
// seven-segment decoder for digits plus hex letters or the player letter set
module seg_decoder
#(
	parameter bit hex_letters = 1'b1
)
(
	input  display_pkg::glyph_t glyph,
	output display_pkg::seg_t   segments
);

	always_comb
	begin
		case (glyph)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0011000;
			4'hA: segments = hex_letters ? 7'b0001000 : 7'b0001100; // A or P
			4'hB: segments = hex_letters ? 7'b0000011 : display_pkg::seg_off; // b or blank
			4'hC: segments = hex_letters ? 7'b1000110 : display_pkg::seg_off;
			4'hD: segments = hex_letters ? 7'b0100001 : display_pkg::seg_off;
			4'hE: segments = hex_letters ? 7'b0000110 : display_pkg::seg_off;
			4'hF: segments = hex_letters ? 7'b0001110 : display_pkg::seg_off;
			default: segments = display_pkg::seg_off;
		endcase
	end

endmodule

/* design/memory_game_top.sv */
// top level: game control, match datapath, scores, countdown and six display decoders
`include "game_defs.svh"

module memory_game_top
#(
	parameter int tick_cycles = `TICK_CYCLES_DEFAULT
)
(
	input  logic                clock,
	input  logic                reset_n,
	input  logic                go_key_n,
	input  game_pkg::card_set_t switches,
	output logic                match_led,
	output logic                turn_led,
	output display_pkg::seg_t   hex0,
	output display_pkg::seg_t   hex2,
	output display_pkg::seg_t   hex4,
	output display_pkg::seg_t   hex5,
	output display_pkg::seg_t   hex6,
	output display_pkg::seg_t   hex7
);

	logic                go;
	logic                select_one;
	logic                select_two;
	logic                check_pulse;
	logic                scored;
	game_pkg::player_t   turn;
	game_pkg::score_t    score_one;
	game_pkg::score_t    score_two;
	display_pkg::lead_t  lead;
	logic [7:0]          count;
	logic                flash_phase;
	display_pkg::glyph_t lead_glyph;
	display_pkg::glyph_t p_glyph;

	assign go       = ~go_key_n; // key pulls low when pressed
	assign turn_led = turn;

	// lead digits blank on odd ticks
	assign p_glyph    = flash_phase ? display_pkg::glyph_blank : display_pkg::glyph_p;
	assign lead_glyph = flash_phase ? display_pkg::glyph_blank : display_pkg::glyph_t'(lead);

	turn_fsm fsm0 (.clock(clock), .reset_n(reset_n), .go(go), .select_one(select_one),
		.select_two(select_two), .check_pulse(check_pulse));

	match_datapath dp0 (.clock(clock), .reset_n(reset_n), .switches(switches),
		.select_one(select_one), .select_two(select_two), .check_pulse(check_pulse),
		.scored(scored), .turn(turn), .match_led(match_led));

	score_keeper sk0 (.clock(clock), .reset_n(reset_n), .scored(scored), .turn(turn),
		.score_one(score_one), .score_two(score_two), .lead(lead));

	countdown_timer #(.tick_cycles(tick_cycles)) tmr0 (.clock(clock), .reset_n(reset_n),
		.count(count), .flash_phase(flash_phase));

	seg_decoder #(.hex_letters(1'b0)) dec_hex0 (.glyph(score_two), .segments(hex0));
	seg_decoder #(.hex_letters(1'b0)) dec_hex2 (.glyph(score_one), .segments(hex2));
	seg_decoder #(.hex_letters(1'b1)) dec_hex4 (.glyph(count[3:0]), .segments(hex4));
	seg_decoder #(.hex_letters(1'b1)) dec_hex5 (.glyph(count[7:4]), .segments(hex5));
	seg_decoder #(.hex_letters(1'b0)) dec_hex6 (.glyph(lead_glyph), .segments(hex6));
	seg_decoder #(.hex_letters(1'b0)) dec_hex7 (.glyph(p_glyph), .segments(hex7));

endmodule

/* sim/tb_model.svh */
// testbench reference model: card partners, pair check, segment table, LFSR, score rules, compares
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`include "game_defs.svh"

// partner of each card, 5 bits per card, card 17 in the top field
localparam logic [18*5-1:0] partner_lut = {
	5'd10, 5'd0, 5'd4, 5'd3, 5'd2, 5'd11, 5'd12, 5'd17, 5'd7,
	5'd5, 5'd9, 5'd1, 5'd8, 5'd15, 5'd14, 5'd13, 5'd6, 5'd16
};

function automatic int partner_of(input int card);
	return int'(partner_lut[card*5 +: 5]);
endfunction

function automatic game_pkg::card_set_t card_bit(input int card);
	return game_pkg::card_set_t'(1) << card;
endfunction

// any card of the first set whose partner is in the second set
function automatic bit pair_match(input game_pkg::card_set_t first,
	input game_pkg::card_set_t second);
	for (int c = 0; c < `CARD_COUNT; c++)
	begin
		if (first[c] && second[partner_of(c)])
			return 1'b1;
	end
	return 1'b0;
endfunction

function automatic display_pkg::seg_t seg_ref(input display_pkg::glyph_t glyph,
	input bit hex_letters);
	logic [6:0] lit; // gfedcba, set means lit
	case (glyph)
		4'h0: lit = 7'b0111111;
		4'h1: lit = 7'b0000110;
		4'h2: lit = 7'b1011011;
		4'h3: lit = 7'b1001111;
		4'h4: lit = 7'b1100110;
		4'h5: lit = 7'b1101101;
		4'h6: lit = 7'b1111101;
		4'h7: lit = 7'b0000111;
		4'h8: lit = 7'b1111111;
		4'h9: lit = 7'b1100111; // no bottom bar
		4'hA: lit = hex_letters ? 7'b1110111 : 7'b1110011; // A or P
		4'hB: lit = 7'b1111100;
		4'hC: lit = 7'b0111001;
		4'hD: lit = 7'b1011110;
		4'hE: lit = 7'b1111001;
		default: lit = 7'b1110001;
	endcase
	if (!hex_letters && glyph > 4'hA)
		lit = '0; // player set has nothing past P
	return ~lit;
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1
endfunction

function automatic game_pkg::score_t score_after(input game_pkg::score_t score, input bit add);
	if (!add)
		return score;
	return (score == `SCORE_MAX) ? game_pkg::score_t'(0) : score + 4'd1;
endfunction

function automatic game_pkg::player_t turn_after(input game_pkg::player_t turn, input bit hit);
	return hit ? turn : ~turn;
endfunction

function automatic display_pkg::lead_t lead_ref(input game_pkg::score_t one,
	input game_pkg::score_t two);
	if (one == two)
		return display_pkg::lead_t'(0);
	return (one > two) ? display_pkg::lead_t'(1) : display_pkg::lead_t'(2);
endfunction

task automatic check_seg(input string what, input display_pkg::seg_t got,
	input display_pkg::seg_t exp);
	if (got !== exp)
		report_error($sformatf("%s is %b, expected %b", what, got, exp));
endtask

task automatic check_score(input string what, input game_pkg::score_t got,
	input game_pkg::score_t exp);
	if (got !== exp)
		report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	if (got !== exp)
		report_error($sformatf("%s is %b, expected %b", what, got, exp));
endtask

`endif

/* sim/memory_game_tb.sv */
// testbench for the memory game: clock, reset, card moves, comparing process and watchdog
module memory_game_tb;

	localparam int tick_cycles     = 16;
	localparam int pair_moves      = 6;
	localparam int miss_moves      = 5; // odd, so player two plays the wrap run
	localparam int wrap_moves      = 10;
	localparam int move_count      = pair_moves + miss_moves + wrap_moves;
	localparam int timer_ticks     = 32;
	localparam int expected_checks = 1 + move_count + timer_ticks * tick_cycles;
	localparam int watchdog_clocks = move_count * 40 + 40 * tick_cycles;

	logic                clock;
	logic                reset_n;
	logic                go_key_n;
	game_pkg::card_set_t switches;
	logic                match_led;
	logic                turn_led;
	display_pkg::seg_t   hex0;
	display_pkg::seg_t   hex2;
	display_pkg::seg_t   hex4;
	display_pkg::seg_t   hex5;
	display_pkg::seg_t   hex6;
	display_pkg::seg_t   hex7;

	game_pkg::score_t    model_score_one;
	game_pkg::score_t    model_score_two;
	game_pkg::player_t   model_turn;
	logic                model_match;
	int                  edges_since_reset = 0;
	logic [31:0]         lfsr_state;
	int                  check_count;
	event                sample_now;

	memory_game_top #(.tick_cycles(tick_cycles)) dut0 (.clock(clock), .reset_n(reset_n),
		.go_key_n(go_key_n), .switches(switches), .match_led(match_led), .turn_led(turn_led),
		.hex0(hex0), .hex2(hex2), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7));

	task automatic report_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	`include "tb_model.svh"

	initial
	begin
		clock = 1'b0;
		forever
			#5 clock = ~clock;
	end

	// tick reference, counts edges after reset release
	always @(posedge clock)
	begin
		if (reset_n)
			edges_since_reset <= edges_since_reset + 1;
	end

	task automatic take_random(input int width, output int value);
		value = 0;
		for (int i = 0; i < width; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic random_card(output int card);
		int bits;
		take_random(5, bits);
		card = bits % `CARD_COUNT;
	endtask

	task automatic press_and_release();
		@(posedge clock);
		#1;
		go_key_n = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		go_key_n = 1'b1;
		repeat (2) @(posedge clock);
	endtask

	// select two cards, check them, then update the model
	task automatic play_move(input int card_a, input int card_b);
		bit hit;
		@(posedge clock);
		#1;
		switches = card_bit(card_a);
		press_and_release(); // card one
		@(posedge clock);
		#1;
		switches = card_bit(card_b);
		press_and_release(); // card two, check on release
		press_and_release(); // back to select one
		repeat (5) @(posedge clock);
		#1;
		hit = pair_match(card_bit(card_a), card_bit(card_b));
		if (model_turn == game_pkg::player_one)
			model_score_one = score_after(model_score_one, hit);
		else
			model_score_two = score_after(model_score_two, hit);
		model_turn  = turn_after(model_turn, hit);
		model_match = hit;
		-> sample_now;
	endtask

	task automatic compare_outputs();
		int                  ticks;
		logic [7:0]          exp_count;
		bit                  blank_phase;
		display_pkg::glyph_t lead_glyph;
		display_pkg::glyph_t p_glyph;
		ticks       = edges_since_reset / tick_cycles;
		exp_count   = `TIMER_RELOAD - 8'(ticks); // wraps through 00
		blank_phase = (ticks % 2) == 1;
		p_glyph     = blank_phase ? display_pkg::glyph_blank : display_pkg::glyph_p;
		lead_glyph  = blank_phase ? display_pkg::glyph_blank :
			display_pkg::glyph_t'(lead_ref(model_score_one, model_score_two));
		check_score("score one", dut0.score_one, model_score_one);
		check_score("score two", dut0.score_two, model_score_two);
		check_flag("match_led", match_led, model_match);
		check_flag("turn_led", turn_led, model_turn);
		check_seg("hex0", hex0, seg_ref(model_score_two, 1'b0));
		check_seg("hex2", hex2, seg_ref(model_score_one, 1'b0));
		check_seg("hex4", hex4, seg_ref(exp_count[3:0], 1'b1));
		check_seg("hex5", hex5, seg_ref(exp_count[7:4], 1'b1));
		check_seg("hex6", hex6, seg_ref(lead_glyph, 1'b0));
		check_seg("hex7", hex7, seg_ref(p_glyph, 1'b0));
		check_count++;
	endtask

	initial
	begin
		forever
		begin
			@(sample_now);
			compare_outputs();
		end
	end

	initial
	begin
		int first;
		int second;
		reset_n         = 1'b0;
		go_key_n        = 1'b1;
		switches        = '0;
		model_score_one = '0;
		model_score_two = '0;
		model_turn      = game_pkg::player_one;
		model_match     = 1'b0;
		lfsr_state      = 32'h3a67;
		check_count     = 0;
		repeat (2) @(posedge clock);
		#1;
		reset_n = 1'b1;
		-> sample_now; // state right after reset
		for (int m = 0; m < pair_moves; m++)
		begin
			random_card(first);
			play_move(first, partner_of(first));
		end
		for (int m = 0; m < miss_moves; m++)
		begin
			random_card(first);
			random_card(second);
			while (pair_match(card_bit(first), card_bit(second)))
				random_card(second);
			play_move(first, second);
		end
		// same player ten times, passes 9 to 0
		for (int m = 0; m < wrap_moves; m++)
		begin
			random_card(first);
			play_move(partner_of(first), first);
		end
		// countdown and flasher, every clock
		repeat (timer_ticks * tick_cycles)
		begin
			@(posedge clock);
			#1;
			-> sample_now;
		end
		@(posedge clock);
		#1;
		if (check_count == expected_checks)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			$display("only %0d of %0d compares ran", check_count, expected_checks);
			$display("TESTBENCH FAILED");
			$fatal(1, "compares missing");
		end
	end

	initial
	begin
		repeat (watchdog_clocks) @(posedge clock);
		$display("watchdog: the run did not finish within %0d clocks", watchdog_clocks);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* flist.f */
+incdir+common
+incdir+sim
common/game_pkg.sv
common/display_pkg.sv
game/turn_fsm.sv
game/match_datapath.sv
design/score_keeper.sv
design/countdown_timer.sv
design/seg_decoder.sv
design/memory_game_top.sv
sim/memory_game_tb.sv
